// File: filelist.f
verilog/scan_pkg.sv
verilog/word_serializer.sv
verilog/word_deserializer.sv
verilog/checkpoint_dma.sv
verilog/scan_ctrl.sv
verilog/checkpoint_ram.sv
verilog/scan_subsystem_top.sv
tb/scan_chain_model.sv
tb/tb_scan_subsystem.sv

// File: tb/scan_chain_model.sv
`timescale 1ns/1ps

module scan_chain_model import scan_pkg::*; #(
    parameter int FF_COUNT  = 100,
    parameter int MEM_COUNT = 70
) (
    input  logic      host_clk,
    input  scan_out_t i_scan,
    output scan_in_t  o_scan
);

    // Position 0 of the flip-flop chain is the one that drives ff_do
    logic [FF_COUNT-1:0]  ff_bits;
    // Bit n of the memory chain sits at pointer value n
    logic [MEM_COUNT-1:0] mem_bits;
    int                   rd_ptr;
    int                   wr_ptr;
    // Two-stage read pipeline, stage 1 is the one seen on ram_do
    logic [1:0]           rd_pipe;
    // Write side keeps the last captured bit until the next step
    logic                 di_cap;
    logic                 cap_vld;

    assign o_scan.ff_do  = ff_bits[0];
    assign o_scan.ram_do = rd_pipe[1];

    initial begin
        ff_bits  = '0;
        mem_bits = '0;
        rd_ptr   = 0;
        wr_ptr   = 0;
        rd_pipe  = '0;
        di_cap   = 1'b0;
        cap_vld  = 1'b0;
    end

    // The chain moves toward position 0 and the new bit enters at the far end
    always @(posedge host_clk) begin
        if (i_scan.ff_se) begin
            ff_bits <= {i_scan.ff_di, ff_bits[FF_COUNT-1:1]};
        end
    end

    always @(posedge host_clk) begin
        if (i_scan.ram_sr) begin
            rd_ptr  <= 0;
            wr_ptr  <= 0;
            cap_vld <= 1'b0;
        end else if (i_scan.ram_se && !i_scan.ram_sd) begin
            // Reading past the end returns zeros
            rd_pipe <= {rd_pipe[0], (rd_ptr < MEM_COUNT) ? mem_bits[rd_ptr] : 1'b0};
            rd_ptr  <= rd_ptr + 1;
        end else if (i_scan.ram_se) begin
            // The first step after a pointer reset has nothing captured yet
            if (cap_vld) begin
                if (wr_ptr < MEM_COUNT) begin
                    mem_bits[wr_ptr] <= di_cap;
                end
                wr_ptr <= wr_ptr + 1;
            end
            di_cap  <= i_scan.ram_di;
            cap_vld <= 1'b1;
        end
    end

endmodule

// File: tb/tb_scan_subsystem.sv
`timescale 1ns/1ps

module tb_scan_subsystem import scan_pkg::*; ();

    localparam int FF_COUNT     = 100;
    localparam int MEM_COUNT    = 70;
    localparam int RAM_DEPTH    = 16;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    // Each scan gets this many cycles before it counts as stuck
    localparam int RUN_CYCLES   = 2000;
    localparam int RUN_COUNT    = 5;
    // Host port traffic and idle checks between the scans
    localparam int HOST_CYCLES  = 500;
    localparam int FF_WORDS     = (FF_COUNT + WORD_W - 1) / WORD_W;
    localparam int MEM_WORDS    = (MEM_COUNT + WORD_W - 1) / WORD_W;
    localparam int IMG_WORDS    = FF_WORDS + MEM_WORDS;
    // Both chains fit in two words each with these lengths
    localparam int REGION_W     = 2 * WORD_W;
    localparam int MARKER_ADDR  = 4;

    logic              host_clk;
    logic              host_rst;
    logic              scan_start;
    logic              scan_dir;
    logic              scan_running;
    scan_out_t         scan_o;
    scan_in_t          scan_i;
    mem_req_t          host_req;
    logic [WORD_W-1:0] host_rdata;
    int                errors;
    // Chain contents that the checkpoint image is expected to hold
    logic [FF_COUNT-1:0]  ff_ref;
    logic [MEM_COUNT-1:0] mem_ref;

    scan_subsystem_top #(
        .FF_COUNT  (FF_COUNT),
        .MEM_COUNT (MEM_COUNT),
        .RAM_DEPTH (RAM_DEPTH)
    ) UUT (
        .host_clk       (host_clk),
        .host_rst       (host_rst),
        .i_scan_start   (scan_start),
        .i_scan_dir     (scan_dir),
        .o_scan_running (scan_running),
        .o_scan         (scan_o),
        .i_scan         (scan_i),
        .i_host_req     (host_req),
        .o_host_rdata   (host_rdata)
    );

    scan_chain_model #(
        .FF_COUNT  (FF_COUNT),
        .MEM_COUNT (MEM_COUNT)
    ) u_chains (
        .host_clk (host_clk),
        .i_scan   (scan_o),
        .o_scan   (scan_i)
    );

    initial begin
        host_clk = 1'b0;
        forever #(CLK_PERIOD / 2) host_clk = ~host_clk;
    end

    initial begin
        #((RUN_COUNT * RUN_CYCLES + RESET_CYCLES + HOST_CYCLES) * CLK_PERIOD);
        $display("ERROR at %0t: watchdog expired before the tests finished", $time);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                               input string msg);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s (got %h, expected %h)", $time, msg, got, exp);
        end
    endtask

    // Word k of a chain region holds chain positions 64k up to 64k+63
    function automatic logic [WORD_W-1:0] region_word(input logic [REGION_W-1:0] bits,
                                                      input int k);
        return bits[k*WORD_W +: WORD_W];
    endfunction

    // The flip-flop region comes first and the memory region follows it
    function automatic logic [WORD_W-1:0] image_word(input int w);
        if (w < FF_WORDS) begin
            return region_word(REGION_W'(ff_ref), w);
        end
        return region_word(REGION_W'(mem_ref), w - FF_WORDS);
    endfunction

    task automatic write_word(input logic [7:0] addr, input logic [WORD_W-1:0] data);
        @(posedge host_clk);
        host_req <= '{en: 1'b1, we: 1'b1, addr: addr, wdata: data};
        @(posedge host_clk);
        host_req <= '0;
    endtask

    // Read data is registered on the edge that samples the request
    task automatic read_word(input logic [7:0] addr, output logic [WORD_W-1:0] data);
        @(posedge host_clk);
        host_req <= '{en: 1'b1, we: 1'b0, addr: addr, wdata: '0};
        @(posedge host_clk);
        host_req <= '0;
        @(negedge host_clk);
        data = host_rdata;
    endtask

    // Chains are only touched between clock edges while no scan is running
    task automatic randomize_chains();
        @(negedge host_clk);
        for (int i = 0; i < FF_COUNT; i++) begin
            u_chains.ff_bits[i] = 1'($urandom);
        end
        for (int i = 0; i < MEM_COUNT; i++) begin
            u_chains.mem_bits[i] = 1'($urandom);
        end
    endtask

    task automatic pulse_start(input logic dir);
        @(posedge host_clk);
        scan_start <= 1'b1;
        scan_dir   <= dir;
        @(posedge host_clk);
        scan_start <= 1'b0;
    endtask

    task automatic wait_scan_done(input string tag);
        int cycles;
        @(negedge host_clk);
        check_value(WORD_W'(scan_running), 1, {tag, " o_scan_running after start"});
        cycles = 0;
        while (scan_running && cycles < RUN_CYCLES) begin
            @(negedge host_clk);
            cycles++;
        end
        if (scan_running) begin
            errors++;
            $display("ERROR at %0t: o_scan_running never fell during %s", $time, tag);
        end
    endtask

    task automatic check_image(input string tag);
        logic [WORD_W-1:0] got;
        for (int w = 0; w < IMG_WORDS; w++) begin
            read_word(8'(w), got);
            check_value(got, image_word(w), $sformatf("%s image word %0d", tag, w));
        end
    endtask

    // Compares the chains word by word, so chain bits beyond the length stay zero
    task automatic compare_chains(input logic [FF_COUNT-1:0] ff_exp,
                                  input logic [MEM_COUNT-1:0] mem_exp,
                                  input logic with_mem, input string tag);
        for (int k = 0; k < FF_WORDS; k++) begin
            check_value(region_word(REGION_W'(u_chains.ff_bits), k),
                        region_word(REGION_W'(ff_exp), k),
                        $sformatf("%s ff chain word %0d", tag, k));
        end
        for (int k = 0; with_mem && k < MEM_WORDS; k++) begin
            check_value(region_word(REGION_W'(u_chains.mem_bits), k),
                        region_word(REGION_W'(mem_exp), k),
                        $sformatf("%s memory chain word %0d", tag, k));
        end
    endtask

    task automatic reset_state_test();
        @(negedge host_clk);
        check_value(WORD_W'(scan_running), 0, "o_scan_running after reset");
        check_value(WORD_W'(scan_o), 0, "scan strobes after reset");
        check_value(WORD_W'(UUT.u_ctrl.o_dma_start), 0, "DMA start after reset");
    endtask

    task automatic scan_out_test();
        randomize_chains();
        ff_ref  = u_chains.ff_bits;
        mem_ref = u_chains.mem_bits;
        pulse_start(1'b0);
        wait_scan_done("scan-out");
        check_image("scan-out");
        // Recirculation leaves the flip-flop chain as it was
        compare_chains(ff_ref, mem_ref, 1'b0, "scan-out");
    endtask

    task automatic scan_in_test();
        logic [WORD_W-1:0]   img [IMG_WORDS];
        logic [REGION_W-1:0] ff_img;
        logic [REGION_W-1:0] mem_img;
        ff_img  = '0;
        mem_img = '0;
        for (int w = 0; w < IMG_WORDS; w++) begin
            img[w] = {$urandom, $urandom};
            write_word(8'(w), img[w]);
        end
        for (int w = 0; w < FF_WORDS; w++) begin
            ff_img[w*WORD_W +: WORD_W] = img[w];
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_img[w*WORD_W +: WORD_W] = img[FF_WORDS + w];
        end
        pulse_start(1'b1);
        wait_scan_done("scan-in");
        // Truncating to the chain lengths leaves the padding bits out
        compare_chains(FF_COUNT'(ff_img), MEM_COUNT'(mem_img), 1'b1, "scan-in");
    endtask

    task automatic round_trip_test();
        randomize_chains();
        ff_ref  = u_chains.ff_bits;
        mem_ref = u_chains.mem_bits;
        pulse_start(1'b0);
        wait_scan_done("round trip out");
        randomize_chains();
        pulse_start(1'b1);
        wait_scan_done("round trip in");
        compare_chains(ff_ref, mem_ref, 1'b1, "round trip");
    endtask

    task automatic restart_ignored_test();
        logic [WORD_W-1:0] marker;
        logic [WORD_W-1:0] got;
        marker = {$urandom, $urandom};
        write_word(8'(MARKER_ADDR), marker);
        randomize_chains();
        ff_ref  = u_chains.ff_bits;
        mem_ref = u_chains.mem_bits;
        pulse_start(1'b0);
        repeat (10) @(posedge host_clk);
        // A taken restart would flip the direction and overwrite the chains
        pulse_start(1'b1);
        wait_scan_done("restart");
        repeat (4) begin
            @(negedge host_clk);
            check_value(WORD_W'(scan_running), 0, "o_scan_running after ignored restart");
        end
        check_image("restart");
        read_word(8'(MARKER_ADDR), got);
        check_value(got, marker, "marker word after restart");
    endtask

    initial begin
        void'($urandom(32'haceec806));
        errors     = 0;
        host_rst   = 1'b1;
        scan_start = 1'b0;
        scan_dir   = 1'b0;
        host_req   = '0;
        repeat (RESET_CYCLES) @(posedge host_clk);
        host_rst <= 1'b0;
        reset_state_test();
        scan_out_test();
        scan_in_test();
        round_trip_test();
        restart_ignored_test();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/checkpoint_dma.sv
`timescale 1ns/1ps

module checkpoint_dma import scan_pkg::*; #(
    parameter int CKPT_WORDS = 4
) (
    input  logic              host_clk,
    input  logic              host_rst,
    input  logic              i_start,
    input  logic              i_dir,
    output logic              o_idle,
    output mem_req_t          o_mem_req,
    input  logic [WORD_W-1:0] i_mem_rdata,
    output logic              o_rd_valid,
    output logic [WORD_W-1:0] o_rd_data,
    input  logic              i_rd_ready,
    input  logic              i_wr_valid,
    input  logic [WORD_W-1:0] i_wr_data,
    output logic              o_wr_ready
);

    localparam int CNT_W = $clog2(CKPT_WORDS + 1);

    logic             rd_busy;
    logic             wr_busy;
    logic [CNT_W-1:0] rd_issued;
    logic [CNT_W-1:0] rd_sent;
    logic [CNT_W-1:0] wr_cnt;
    // A read issued last cycle whose data lands in the buffer this cycle
    logic             rd_pend;
    logic [WORD_W-1:0] skid_mem [2];
    logic             skid_wp;
    logic             skid_rp;
    logic [1:0]       skid_cnt;
    logic             rd_issue;
    logic             rd_pop;
    logic             wr_xfer;

    assign o_idle = !rd_busy && !wr_busy;

    // Reads stop while the buffer plus the read in flight would fill it
    assign rd_issue = rd_busy && (rd_issued != CNT_W'(CKPT_WORDS)) &&
                      ((skid_cnt + {1'b0, rd_pend}) < 2'd2);
    assign o_rd_valid = skid_cnt != 2'd0;
    assign o_rd_data  = skid_mem[skid_rp];
    assign rd_pop     = o_rd_valid && i_rd_ready;

    // The write engine takes one word per cycle for the whole transfer
    assign o_wr_ready = wr_busy;
    assign wr_xfer    = wr_busy && i_wr_valid;

    // Only one engine runs at a time, so the port is simply shared
    always_comb begin
        o_mem_req.en    = rd_issue || wr_xfer;
        o_mem_req.we    = wr_xfer;
        o_mem_req.addr  = rd_busy ? 8'(rd_issued) : 8'(wr_cnt);
        o_mem_req.wdata = i_wr_data;
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            rd_busy   <= 1'b0;
            wr_busy   <= 1'b0;
            rd_pend   <= 1'b0;
            rd_issued <= '0;
            rd_sent   <= '0;
            wr_cnt    <= '0;
            skid_wp   <= 1'b0;
            skid_rp   <= 1'b0;
            skid_cnt  <= '0;
        end else if (o_idle) begin
            if (i_start) begin
                rd_busy   <= i_dir;
                wr_busy   <= !i_dir;
                rd_issued <= '0;
                rd_sent   <= '0;
                wr_cnt    <= '0;
                skid_wp   <= 1'b0;
                skid_rp   <= 1'b0;
                skid_cnt  <= '0;
            end
        end else begin
            rd_pend <= rd_issue;
            if (rd_issue) begin
                rd_issued <= rd_issued + 1'b1;
            end
            if (rd_pend) begin
                skid_wp <= !skid_wp;
            end
            if (rd_pop) begin
                skid_rp <= !skid_rp;
                rd_sent <= rd_sent + 1'b1;
                // The read side is done once the last word has been handed on
                if (rd_sent == CNT_W'(CKPT_WORDS - 1)) begin
                    rd_busy <= 1'b0;
                end
            end
            skid_cnt <= skid_cnt + {1'b0, rd_pend} - {1'b0, rd_pop};
            if (wr_xfer) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == CNT_W'(CKPT_WORDS - 1)) begin
                    wr_busy <= 1'b0;
                end
            end
        end
    end

    // Read data arrives one cycle after its request
    always_ff @(posedge host_clk) begin
        if (rd_pend) begin
            skid_mem[skid_wp] <= i_mem_rdata;
        end
    end

endmodule

// File: verilog/checkpoint_ram.sv
`timescale 1ns/1ps

module checkpoint_ram import scan_pkg::*; #(
    parameter int RAM_DEPTH = 16
) (
    input  logic              host_clk,
    input  mem_req_t          i_dma_req,
    output logic [WORD_W-1:0] o_dma_rdata,
    input  mem_req_t          i_host_req,
    output logic [WORD_W-1:0] o_host_rdata
);

    localparam int AW = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    logic [WORD_W-1:0] mem [RAM_DEPTH];
    logic [AW-1:0]     dma_a;
    logic [AW-1:0]     host_a;

    // Only the low address bits select a word
    assign dma_a  = i_dma_req.addr[AW-1:0];
    assign host_a = i_host_req.addr[AW-1:0];

    always_ff @(posedge host_clk) begin
        // Host write first so that a DMA write to the same word wins
        if (i_host_req.en && i_host_req.we) begin
            mem[host_a] <= i_host_req.wdata;
        end
        if (i_dma_req.en && i_dma_req.we) begin
            mem[dma_a] <= i_dma_req.wdata;
        end
    end

    // Registered reads return the old word on a read during write
    always_ff @(posedge host_clk) begin
        if (i_dma_req.en) begin
            o_dma_rdata <= mem[dma_a];
        end
    end

    always_ff @(posedge host_clk) begin
        if (i_host_req.en) begin
            o_host_rdata <= mem[host_a];
        end
    end

endmodule

// File: verilog/scan_ctrl.sv
`timescale 1ns/1ps

module scan_ctrl import scan_pkg::*; #(
    parameter int FF_COUNT  = 100,
    parameter int MEM_COUNT = 70
) (
    input  logic              host_clk,
    input  logic              host_rst,
    input  logic              i_start,
    input  logic              i_dir,
    output logic              o_running,
    output scan_out_t         o_scan,
    input  scan_in_t          i_scan,
    output logic              o_dma_start,
    output logic              o_dma_dir,
    input  logic              i_dma_idle,
    input  logic              i_rd_valid,
    input  logic [WORD_W-1:0] i_rd_data,
    output logic              o_rd_ready,
    output logic              o_wr_valid,
    output logic [WORD_W-1:0] o_wr_data,
    input  logic              i_wr_ready
);

    // Counters keep at least one bit so an empty chain still elaborates
    localparam int FF_CNT_W  = (FF_COUNT > 0) ? $clog2(FF_COUNT + 1) : 1;
    localparam int MEM_CNT_W = (MEM_COUNT > 0) ? $clog2(MEM_COUNT + 1) : 1;

    scan_state_e          state, state_next;
    logic                 dir_q;
    logic [FF_CNT_W-1:0]  ff_cnt;
    logic [MEM_CNT_W-1:0] ram_cnt;
    logic                 ser_clear;
    logic                 ser_valid, ser_ready, ser_bit;
    logic                 des_valid, des_ready, des_bit;
    logic                 des_valid_in;
    logic                 scan_valid;
    logic                 ff_last, ram_last;

    // Chains advance only when the bit stream can move in the active direction
    assign scan_valid = dir_q ? ser_valid : des_ready;
    assign ff_last    = scan_valid && state == FF_SCAN &&
                        ff_cnt == FF_CNT_W'(FF_COUNT - 1);
    assign ram_last   = scan_valid && state == RAM_SCAN &&
                        ram_cnt == MEM_CNT_W'(MEM_COUNT - 1);

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            state <= IDLE;
            dir_q <= 1'b0;
        end else begin
            state <= state_next;
            // Direction is held for the whole run
            if (state == IDLE && i_start) begin
                dir_q <= i_dir;
            end
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:       if (i_start) state_next = DMA_START;
            DMA_START:  state_next = FF_RESET;
            FF_RESET:   state_next = (FF_COUNT == 0) ? RAM_RESET : FF_SCAN;
            FF_SCAN: begin
                if (ff_last) begin
                    // Scan-out pads the last partial word with zeros
                    if (dir_q || FF_COUNT % WORD_W == 0) state_next = RAM_RESET;
                    else state_next = FF_PAD;
                end
            end
            FF_PAD:     if (des_valid) state_next = RAM_RESET;
            RAM_RESET: begin
                if (MEM_COUNT == 0) state_next = WAIT_DMA;
                else if (dir_q) state_next = RAM_SCAN;
                else state_next = RAM_PREP_1;
            end
            RAM_PREP_1: state_next = RAM_PREP_2;
            RAM_PREP_2: state_next = RAM_SCAN;
            RAM_SCAN: begin
                if (ram_last) begin
                    if (dir_q) state_next = RAM_POST;
                    else if (MEM_COUNT % WORD_W == 0) state_next = WAIT_DMA;
                    else state_next = RAM_PAD;
                end
            end
            RAM_POST:   state_next = WAIT_DMA;
            RAM_PAD:    if (des_valid) state_next = WAIT_DMA;
            WAIT_DMA:   if (i_dma_idle) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    // Chain counters restart in their reset states and count accepted bits
    always_ff @(posedge host_clk) begin
        if (host_rst || state == FF_RESET) begin
            ff_cnt <= '0;
        end else if (scan_valid && state == FF_SCAN) begin
            ff_cnt <= ff_cnt + 1'b1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst || state == RAM_RESET) begin
            ram_cnt <= '0;
        end else if (scan_valid && state == RAM_SCAN) begin
            ram_cnt <= ram_cnt + 1'b1;
        end
    end

    assign o_running   = state != IDLE;
    assign o_dma_start = state == DMA_START;
    assign o_dma_dir   = dir_q;

    // Leftover bits of a chain region are dropped at each chain reset
    assign ser_clear = state == FF_RESET || state == RAM_RESET;

    // Scan-in keeps draining bits after the last chain so the DMA can finish
    assign ser_ready = dir_q && (state == FF_SCAN || state == RAM_SCAN ||
                                 state == WAIT_DMA);

    // Scan-out feeds chain bits and then zero padding into the deserializer
    assign des_valid_in = !dir_q && (state == FF_SCAN || state == FF_PAD ||
                                     state == RAM_SCAN || state == RAM_PAD);
    assign des_bit      = (state == FF_SCAN)  ? i_scan.ff_do :
                          (state == RAM_SCAN) ? i_scan.ram_do : 1'b0;

    always_comb begin
        o_scan.ff_se  = scan_valid && state == FF_SCAN;
        // Scan-in loads the serial bit while scan-out feeds the chain its own output
        o_scan.ff_di  = scan_valid && state == FF_SCAN &&
                        (dir_q ? ser_bit : i_scan.ff_do);
        o_scan.ram_sr = state == RAM_RESET;
        // Two read steps prime the memory chain and one write step flushes it
        o_scan.ram_se = (scan_valid && state == RAM_SCAN) || state == RAM_PREP_1 ||
                        state == RAM_PREP_2 || state == RAM_POST;
        o_scan.ram_sd = dir_q && state != IDLE;
        o_scan.ram_di = dir_q && scan_valid && state == RAM_SCAN && ser_bit;
    end

    word_serializer u_ser (
        .host_clk (host_clk),
        .host_rst (host_rst),
        .i_clear  (ser_clear),
        .i_valid  (i_rd_valid),
        .i_data   (i_rd_data),
        .o_ready  (o_rd_ready),
        .o_valid  (ser_valid),
        .o_data   (ser_bit),
        .i_ready  (ser_ready)
    );

    word_deserializer u_des (
        .host_clk (host_clk),
        .host_rst (host_rst),
        .i_clear  (ser_clear),
        .i_valid  (des_valid_in),
        .i_data   (des_bit),
        .o_ready  (des_ready),
        .o_valid  (des_valid),
        .o_data   (o_wr_data),
        .i_ready  (i_wr_ready)
    );

    // Finished words go straight to the DMA write engine
    assign o_wr_valid = des_valid;

endmodule

// File: verilog/scan_pkg.sv
package scan_pkg;

    // Width of one checkpoint word in the RAM and on the word streams
    localparam int WORD_W = 64;

    // Strobes and data bits driven into the emulated design's scan chains
    typedef struct packed {
        // Shift the flip-flop chain by one position
        logic ff_se;
        // Bit that enters the flip-flop chain at its far end
        logic ff_di;
        // Clear the read and write pointers of the memory chain
        logic ram_sr;
        // Step the memory chain by one bit
        logic ram_se;
        // Memory chain direction, high writes into the memories
        logic ram_sd;
        // Bit written into the memory chain
        logic ram_di;
    } scan_out_t;

    // Bits returned by the scan chains
    typedef struct packed {
        logic ff_do;
        logic ram_do;
    } scan_in_t;

    // One request on a checkpoint RAM port, read data follows a cycle later
    typedef struct packed {
        logic              en;
        logic              we;
        logic [7:0]        addr;
        logic [WORD_W-1:0] wdata;
    } mem_req_t;

    // Scan sequencer states, in the order a full scan walks through them
    typedef enum logic [3:0] {
        IDLE, DMA_START, FF_RESET, FF_SCAN, FF_PAD, RAM_RESET, RAM_PREP_1,
        RAM_PREP_2, RAM_SCAN, RAM_POST, RAM_PAD, WAIT_DMA
    } scan_state_e;

endpackage

// File: verilog/scan_subsystem_top.sv
`timescale 1ns/1ps

module scan_subsystem_top import scan_pkg::*; #(
    parameter int FF_COUNT  = 100,
    parameter int MEM_COUNT = 70,
    parameter int RAM_DEPTH = 16
) (
    input  logic              host_clk,
    input  logic              host_rst,
    input  logic              i_scan_start,
    input  logic              i_scan_dir,
    output logic              o_scan_running,
    output scan_out_t         o_scan,
    input  scan_in_t          i_scan,
    input  mem_req_t          i_host_req,
    output logic [WORD_W-1:0] o_host_rdata
);

    // Each chain starts on a fresh word, so both lengths round up separately
    localparam int CKPT_WORDS = (FF_COUNT + WORD_W - 1) / WORD_W +
                                (MEM_COUNT + WORD_W - 1) / WORD_W;

    logic              dma_start, dma_dir, dma_idle;
    mem_req_t          dma_req;
    logic [WORD_W-1:0] dma_rdata;
    logic              rd_valid, rd_ready;
    logic [WORD_W-1:0] rd_data;
    logic              wr_valid, wr_ready;
    logic [WORD_W-1:0] wr_data;

    scan_ctrl #(
        .FF_COUNT  (FF_COUNT),
        .MEM_COUNT (MEM_COUNT)
    ) u_ctrl (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .i_start     (i_scan_start),
        .i_dir       (i_scan_dir),
        .o_running   (o_scan_running),
        .o_scan      (o_scan),
        .i_scan      (i_scan),
        .o_dma_start (dma_start),
        .o_dma_dir   (dma_dir),
        .i_dma_idle  (dma_idle),
        .i_rd_valid  (rd_valid),
        .i_rd_data   (rd_data),
        .o_rd_ready  (rd_ready),
        .o_wr_valid  (wr_valid),
        .o_wr_data   (wr_data),
        .i_wr_ready  (wr_ready)
    );

    checkpoint_dma #(
        .CKPT_WORDS (CKPT_WORDS)
    ) u_dma (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .i_start     (dma_start),
        .i_dir       (dma_dir),
        .o_idle      (dma_idle),
        .o_mem_req   (dma_req),
        .i_mem_rdata (dma_rdata),
        .o_rd_valid  (rd_valid),
        .o_rd_data   (rd_data),
        .i_rd_ready  (rd_ready),
        .i_wr_valid  (wr_valid),
        .i_wr_data   (wr_data),
        .o_wr_ready  (wr_ready)
    );

    checkpoint_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_ram (
        .host_clk     (host_clk),
        .i_dma_req    (dma_req),
        .o_dma_rdata  (dma_rdata),
        .i_host_req   (i_host_req),
        .o_host_rdata (o_host_rdata)
    );

endmodule

// File: verilog/word_deserializer.sv
`timescale 1ns/1ps

module word_deserializer import scan_pkg::*; (
    input  logic              host_clk,
    input  logic              host_rst,
    input  logic              i_clear,
    input  logic              i_valid,
    input  logic              i_data,
    output logic              o_ready,
    output logic              o_valid,
    output logic [WORD_W-1:0] o_data,
    input  logic              i_ready
);

    logic [WORD_W-1:0]         word_q;
    logic [$clog2(WORD_W)-1:0] cnt_q;
    logic                      full_q;
    logic                      bit_xfer;

    // New bits are refused while a finished word waits downstream
    assign o_ready  = !full_q;
    assign o_valid  = full_q;
    assign o_data   = word_q;
    assign bit_xfer = i_valid && !full_q;

    always_ff @(posedge host_clk) begin
        if (host_rst || i_clear) begin
            full_q <= 1'b0;
            cnt_q  <= '0;
        end else if (full_q) begin
            if (i_ready) begin
                full_q <= 1'b0;
            end
        end else if (bit_xfer) begin
            // Counter wraps to zero on the last bit of the word
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == $clog2(WORD_W)'(WORD_W - 1)) begin
                full_q <= 1'b1;
            end
        end
    end

    // Bits enter at the top so that the first one ends up in bit 0
    always_ff @(posedge host_clk) begin
        if (bit_xfer) begin
            word_q <= {i_data, word_q[WORD_W-1:1]};
        end
    end

endmodule

// File: verilog/word_serializer.sv
`timescale 1ns/1ps

module word_serializer import scan_pkg::*; (
    input  logic              host_clk,
    input  logic              host_rst,
    input  logic              i_clear,
    input  logic              i_valid,
    input  logic [WORD_W-1:0] i_data,
    output logic              o_ready,
    output logic              o_valid,
    output logic              o_data,
    input  logic              i_ready
);

    logic [WORD_W-1:0]         word_q;
    logic [$clog2(WORD_W)-1:0] idx_q;
    logic                      full_q;

    // A new word is only taken once the held one has gone out completely
    // No word is taken on a clear cycle since the clear would drop it
    assign o_ready = !full_q && !i_clear;
    assign o_valid = full_q;
    // Least significant bit leaves first
    assign o_data  = word_q[idx_q];

    always_ff @(posedge host_clk) begin
        if (host_rst || i_clear) begin
            full_q <= 1'b0;
            idx_q  <= '0;
        end else if (!full_q && i_valid) begin
            full_q <= 1'b1;
            idx_q  <= '0;
        end else if (full_q && i_ready) begin
            // The word is released when its top bit transfers
            if (idx_q == $clog2(WORD_W)'(WORD_W - 1)) begin
                full_q <= 1'b0;
            end
            idx_q <= idx_q + 1'b1;
        end
    end

    // Word payload is only read while full_q is set
    always_ff @(posedge host_clk) begin
        if (!full_q && i_valid) begin
            word_q <= i_data;
        end
    end

endmodule
